//--- compile.f
+incdir+src
src/icache_pkg.sv
src/icache_victim_if.sv
src/icache_victim.sv
src/icache_main_array.sv
src/icache_line_fill.sv
src/icache_control.sv
src/icache_top.sv
testbench/icache_assertions.sv
testbench/icache_tb.sv

//--- src/icache_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icache_control (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           fetch_cyc,
    input  logic                                           fetch_stb,
    input  logic [`ICACHE_ADDR_W-1:0]                      fetch_adr,
    output logic                                           fetch_ack,
    output logic [31:0]                                    fetch_dat,
    input  logic                                           main_hit,
    input  logic                                           main_valid,
    input  logic [`ICACHE_VTAG_W-$clog2(`ICACHE_SETS)-1:0] main_tag_out,
    input  icache_pkg::line_t                              main_line_out,
    output logic [$clog2(`ICACHE_SETS)-1:0]                main_index,
    output logic [`ICACHE_VTAG_W-$clog2(`ICACHE_SETS)-1:0] main_tag,
    output logic                                           main_load,
    output icache_pkg::line_t                              main_line_in,
    output logic                                           fill_start,
    output icache_pkg::line_addr_t                         fill_addr,
    input  logic                                           fill_done,
    input  icache_pkg::line_t                              fill_line,
    icache_victim_if.ctrl                                  vbus
);
    import icache_pkg::*;

    ctrl_state_t state, next_state;
    logic        repl_way;
    logic        way;
    logic [1:0]  way_sel;
    line_addr_t  line_addr;

    // ==============================
    // Address split
    // ==============================

    assign line_addr  = fetch_adr[`ICACHE_ADDR_W-1:5];
    assign main_index = line_addr[$clog2(`ICACHE_SETS)-1:0];
    assign main_tag   = line_addr[`ICACHE_VTAG_W-1:$clog2(`ICACHE_SETS)];
    assign fill_addr  = line_addr;

    assign vbus.lookup_addr = line_addr;
    assign vbus.evict_addr  = {main_tag_out, main_index};  // Line leaving main
    assign vbus.evict_line  = main_line_out;

    // First free way, else LRU
    assign repl_way = !vbus.valid_out[0] ? 1'b0 :
                      !vbus.valid_out[1] ? 1'b1 : vbus.lru;
    assign way      = (state == SWAP) ? vbus.hit_way : repl_way;
    assign way_sel  = way ? 2'b10 : 2'b01;

    // ==============================
    // FSM
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state    = state;
        main_load     = 1'b0;
        main_line_in  = vbus.hit_line;
        fill_start    = 1'b0;
        vbus.ld_valid = 2'b00;
        vbus.ld_tag   = 2'b00;
        vbus.ld_data  = 2'b00;
        vbus.ld_lru   = 1'b0;
        vbus.lru_in   = ~way;
        vbus.valid_in = main_valid;

        case (state)
            IDLE: begin
                if (fetch_cyc && fetch_stb) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                // Also the write cycle after a swap or fill, which then hits main
                if (main_hit) begin
                    next_state = RESPOND;
                end else if (vbus.hit) begin
                    next_state = SWAP;
                end else begin
                    next_state = EVICT;
                end
            end
            SWAP: begin
                main_load     = 1'b1;
                vbus.ld_valid = way_sel;  // Clears the way if main was empty
                vbus.ld_tag   = way_sel;
                vbus.ld_data  = way_sel;
                vbus.ld_lru   = 1'b1;
                next_state    = LOOKUP;
            end
            EVICT: begin
                if (main_valid) begin
                    vbus.ld_valid = way_sel;
                    vbus.ld_tag   = way_sel;
                    vbus.ld_data  = way_sel;
                    vbus.ld_lru   = 1'b1;
                end
                fill_start = 1'b1;
                next_state = FILL;
            end
            FILL: begin
                main_line_in = fill_line;
                if (fill_done) begin
                    main_load  = 1'b1;
                    next_state = LOOKUP;
                end
            end
            RESPOND: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    assign fetch_ack = (state == RESPOND);

    // Addressed word, captured on the main hit
    always_ff @(posedge clk) begin
        if (state == LOOKUP && main_hit) begin
            fetch_dat <= main_line_out[32*fetch_adr[4:2] +: 32];
        end
    end

endmodule

`default_nettype wire

//--- src/icache_line_fill.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icache_line_fill (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fill_start,
    input  icache_pkg::line_addr_t     fill_addr,
    input  logic                       mem_ack,
    input  logic [31:0]                mem_dat,
    output logic                       fill_done,
    output icache_pkg::line_t          fill_line,
    output logic                       mem_cyc,
    output logic                       mem_stb,
    output logic [`ICACHE_ADDR_W-1:0]  mem_adr
);
    import icache_pkg::*;

    logic                              busy;
    logic [$clog2(`ICACHE_WORDS)-1:0]  cnt_q;  // Current word offset
    line_addr_t                        base_q;

    // Strobe stays up across words, address held through wait states
    assign mem_cyc = busy;
    assign mem_stb = busy;
    assign mem_adr = {base_q, cnt_q, 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            cnt_q     <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            if (!busy && fill_start) begin
                busy  <= 1'b1;
                cnt_q <= '0;
            end else if (busy && mem_ack) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == `ICACHE_WORDS - 1) begin
                    busy      <= 1'b0;
                    fill_done <= 1'b1;   // Eighth word in
                end
            end
        end
    end

    // Line assembly, word k at bit 32k
    always_ff @(posedge clk) begin
        if (!busy && fill_start) begin
            base_q <= fill_addr;
        end
        if (busy && mem_ack) begin
            fill_line[32*cnt_q +: 32] <= mem_dat;
        end
    end

endmodule

`default_nettype wire

//--- src/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// ==============================
// Cache geometry
// ==============================

`define ICACHE_ADDR_W 32    // Byte address
`define ICACHE_LINE_W 256   // One line, 32 bytes
`define ICACHE_WORDS  8     // 32-bit words per line
`define ICACHE_SETS   8     // Direct-mapped main sets

// Line address, bits 31 to 5
`define ICACHE_VTAG_W 27

`endif

//--- src/icache_main_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icache_main_array (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic [$clog2(`ICACHE_SETS)-1:0]                main_index,
    input  logic [`ICACHE_VTAG_W-$clog2(`ICACHE_SETS)-1:0] main_tag,
    input  logic                                           main_load,
    input  icache_pkg::line_t                              main_line_in,
    output logic                                           main_hit,
    output logic                                           main_valid,
    output logic [`ICACHE_VTAG_W-$clog2(`ICACHE_SETS)-1:0] main_tag_out,
    output icache_pkg::line_t                              main_line_out
);
    import icache_pkg::*;

    localparam int TAG_W = `ICACHE_VTAG_W - $clog2(`ICACHE_SETS);

    logic [`ICACHE_SETS-1:0] valid_q;
    logic [TAG_W-1:0]        tag_q [`ICACHE_SETS];
    line_t                   data_q [`ICACHE_SETS];

    // ==============================
    // Write port
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (main_load) begin
            valid_q[main_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            tag_q[main_index]  <= main_tag;
            data_q[main_index] <= main_line_in;
        end
    end

    // ==============================
    // Read port
    // ==============================

    // Combinational read of the indexed set
    assign main_valid    = valid_q[main_index];
    assign main_tag_out  = tag_q[main_index];
    assign main_line_out = data_q[main_index];

    assign main_hit = main_valid && (main_tag_out == main_tag);

endmodule

`default_nettype wire

//--- src/icache_pkg.sv
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

    // Control sequence for one fetch
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        SWAP,
        EVICT,
        FILL,
        RESPOND
    } ctrl_state_t;

    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    // Full line address, used as victim tag
    typedef logic [`ICACHE_VTAG_W-1:0] line_addr_t;

endpackage

`default_nettype wire

//--- src/icache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst,
    // Fetch side, Wishbone slave
    input  logic                      fetch_cyc,
    input  logic                      fetch_stb,
    input  logic [`ICACHE_ADDR_W-1:0] fetch_adr,
    output logic                      fetch_ack,
    output logic [31:0]               fetch_dat,
    // Memory side, Wishbone master
    output logic                      mem_cyc,
    output logic                      mem_stb,
    output logic [`ICACHE_ADDR_W-1:0] mem_adr,
    input  logic                      mem_ack,
    input  logic [31:0]               mem_dat
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(`ICACHE_SETS);
    localparam int TAG_W = `ICACHE_VTAG_W - IDX_W;

    logic [IDX_W-1:0] main_index;
    logic [TAG_W-1:0] main_tag;
    logic [TAG_W-1:0] main_tag_out;
    logic             main_load;
    logic             main_hit;
    logic             main_valid;
    line_t            main_line_in;
    line_t            main_line_out;
    logic             fill_start;
    logic             fill_done;
    line_addr_t       fill_addr;
    line_t            fill_line;

    icache_victim_if vbus ();

    icache_control icache_control_inst (
        .clk           (clk),
        .rst           (rst),
        .fetch_cyc     (fetch_cyc),
        .fetch_stb     (fetch_stb),
        .fetch_adr     (fetch_adr),
        .fetch_ack     (fetch_ack),
        .fetch_dat     (fetch_dat),
        .main_hit      (main_hit),
        .main_valid    (main_valid),
        .main_tag_out  (main_tag_out),
        .main_line_out (main_line_out),
        .main_index    (main_index),
        .main_tag      (main_tag),
        .main_load     (main_load),
        .main_line_in  (main_line_in),
        .fill_start    (fill_start),
        .fill_addr     (fill_addr),
        .fill_done     (fill_done),
        .fill_line     (fill_line),
        .vbus          (vbus)
    );

    icache_victim icache_victim_inst (
        .clk (clk),
        .rst (rst),
        .bus (vbus)
    );

    icache_main_array icache_main_array_inst (
        .clk           (clk),
        .rst           (rst),
        .main_index    (main_index),
        .main_tag      (main_tag),
        .main_load     (main_load),
        .main_line_in  (main_line_in),
        .main_hit      (main_hit),
        .main_valid    (main_valid),
        .main_tag_out  (main_tag_out),
        .main_line_out (main_line_out)
    );

    icache_line_fill icache_line_fill_inst (
        .clk        (clk),
        .rst        (rst),
        .fill_start (fill_start),
        .fill_addr  (fill_addr),
        .mem_ack    (mem_ack),
        .mem_dat    (mem_dat),
        .fill_done  (fill_done),
        .fill_line  (fill_line),
        .mem_cyc    (mem_cyc),
        .mem_stb    (mem_stb),
        .mem_adr    (mem_adr)
    );

endmodule

`default_nettype wire

//--- src/icache_victim.sv
`timescale 1ns/1ns
`default_nettype none

module icache_victim (
    input logic          clk,
    input logic          rst,
    icache_victim_if.buffer bus
);
    import icache_pkg::*;

    logic [1:0] valid_q;
    logic       lru_q;
    line_addr_t tag_q [2];
    line_t      data_q [2];
    logic [1:0] match;

    // ==============================
    // Lookup
    // ==============================

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            match[i] = valid_q[i] && (tag_q[i] == bus.lookup_addr);
        end
    end

    // Lines are exclusive, so at most one way matches
    assign bus.hit       = |match;
    assign bus.hit_way   = match[1];
    assign bus.valid_out = valid_q;
    assign bus.lru       = lru_q;

    always_ff @(posedge clk) begin
        if (bus.hit) begin
            bus.hit_line <= data_q[bus.hit_way];
        end
    end

    // ==============================
    // Storage
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            lru_q   <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (bus.ld_valid[i]) begin
                    valid_q[i] <= bus.valid_in;
                end
            end
            if (bus.ld_lru) begin
                lru_q <= bus.lru_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (bus.ld_tag[i]) begin
                tag_q[i] <= bus.evict_addr;
            end
            if (bus.ld_data[i]) begin
                data_q[i] <= bus.evict_line;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/icache_victim_if.sv
`timescale 1ns/1ns
`default_nettype none

interface icache_victim_if;
    import icache_pkg::*;

    // Control to buffer
    line_addr_t lookup_addr;
    line_addr_t evict_addr;
    line_t      evict_line;
    logic [1:0] ld_valid;
    logic [1:0] ld_tag;
    logic [1:0] ld_data;
    logic       ld_lru;
    logic       lru_in;
    logic       valid_in;

    // Buffer to control
    logic       hit;
    logic       hit_way;
    logic [1:0] valid_out;
    logic       lru;
    line_t      hit_line;   // Registered

    modport ctrl (
        output lookup_addr, evict_addr, evict_line,
        output ld_valid, ld_tag, ld_data, ld_lru, lru_in, valid_in,
        input  hit, hit_way, valid_out, lru, hit_line
    );

    modport buffer (
        input  lookup_addr, evict_addr, evict_line,
        input  ld_valid, ld_tag, ld_data, ld_lru, lru_in, valid_in,
        output hit, hit_way, valid_out, lru, hit_line
    );

endinterface

`default_nettype wire

//--- testbench/icache_assertions.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icache_assertions (
    input logic                      clk,
    input logic                      rst,
    input logic                      fetch_cyc,
    input logic                      fetch_stb,
    input logic                      fetch_ack,
    input logic                      mem_cyc,
    input logic                      mem_stb,
    input logic                      mem_ack,
    input logic [`ICACHE_ADDR_W-1:0] mem_adr
);

    int fail_count = 0;  // Failed assertions so far

    // Sampled mid-cycle where strobe and ack overlap
    ack_inside_cycle: assert property (
        @(negedge clk) disable iff (rst) fetch_ack |-> (fetch_cyc && fetch_stb)
    ) else begin
        fail_count++;
        $error("fetch_ack seen without fetch_cyc and fetch_stb");
    end

    stb_inside_cyc: assert property (
        @(posedge clk) disable iff (rst) mem_stb |-> mem_cyc
    ) else begin
        fail_count++;
        $error("mem_stb high while mem_cyc is low");
    end

    // Address held through wait states
    adr_held: assert property (
        @(posedge clk) disable iff (rst) (mem_stb && !mem_ack) |=> $stable(mem_adr)
    ) else begin
        fail_count++;
        $error("mem_adr changed before mem_ack");
    end

    ack_single: assert property (
        @(posedge clk) disable iff (rst) fetch_ack |=> !fetch_ack
    ) else begin
        fail_count++;
        $error("fetch_ack high for more than one cycle");
    end

endmodule

`default_nettype wire

//--- testbench/icache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icache_tb;
    import icache_pkg::*;

    // Roughly 30 misses of 38 cycles or less plus hits and resets
    localparam int CYCLE_LIMIT = 4000;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      fetch_cyc;
    logic                      fetch_stb;
    logic [`ICACHE_ADDR_W-1:0] fetch_adr;
    logic                      fetch_ack;
    logic [31:0]               fetch_dat;
    logic                      mem_cyc;
    logic                      mem_stb;
    logic [`ICACHE_ADDR_W-1:0] mem_adr;
    logic                      mem_ack = 1'b0;
    logic [31:0]               mem_dat = '0;

    int          cycle_count = 0;
    int          error_count = 0;
    int          xfer_count = 0;
    logic [31:0] xfer_addrs [$];
    logic [31:0] delay_state = 32'd59;
    logic [31:0] addr_state = 32'd59;
    int          wait_left = 0;

    // Expected cache contents by line address
    line_addr_t  ref_main [`ICACHE_SETS];
    bit          ref_main_valid [`ICACHE_SETS];
    line_addr_t  ref_way [2];
    bit          ref_way_valid [2];
    bit          ref_lru;

    icache_top icache_top_inst (
        .clk       (clk),
        .rst       (rst),
        .fetch_cyc (fetch_cyc),
        .fetch_stb (fetch_stb),
        .fetch_adr (fetch_adr),
        .fetch_ack (fetch_ack),
        .fetch_dat (fetch_dat),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_adr   (mem_adr),
        .mem_ack   (mem_ack),
        .mem_dat   (mem_dat)
    );

    bind icache_top icache_assertions icache_assertions_inst (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: no result after %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $fatal(1, "simulation stopped");
        end
    end

    always @(negedge clk) begin
        if (icache_top_inst.icache_assertions_inst.fail_count != 0) begin
            $display("A bound Wishbone protocol assertion failed");
            $display("FAIL: see errors above");
            $fatal(1, "protocol violation");
        end
    end

    // ==============================
    // Memory model
    // ==============================

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always @(negedge clk) begin
        if (rst || !(mem_cyc && mem_stb)) begin
            mem_ack <= 1'b0;
        end else if (wait_left == 0) begin
            mem_ack <= 1'b1;
            mem_dat <= mem_adr ^ 32'hA5A5_0000;
            delay_state = xorshift(delay_state);
            wait_left = delay_state[1:0];  // 0 to 3 wait states for the next word
        end else begin
            mem_ack <= 1'b0;
            wait_left = wait_left - 1;
        end
    end

    // Completed transfers at the edge that takes them
    always @(posedge clk) begin
        if (mem_cyc && mem_stb && mem_ack) begin
            xfer_addrs.push_back(mem_adr);
            xfer_count = xfer_count + 1;
        end
    end

    // ==============================
    // Reference and helpers
    // ==============================

    // Returns 1 when the fetch must go to memory
    function automatic bit ref_access(input line_addr_t la);
        int         set;
        int         w;
        line_addr_t old_line;
        bit         old_valid;
        set = la[2:0];
        old_line = ref_main[set];
        old_valid = ref_main_valid[set];
        if (old_valid && old_line == la) begin
            return 1'b0;
        end
        ref_main[set] = la;
        ref_main_valid[set] = 1'b1;
        for (int i = 0; i < 2; i++) begin
            if (ref_way_valid[i] && ref_way[i] == la) begin
                ref_way[i] = old_line;         // Swap
                ref_way_valid[i] = old_valid;
                ref_lru = (i == 0);
                return 1'b0;
            end
        end
        if (old_valid) begin
            w = !ref_way_valid[0] ? 0 : (!ref_way_valid[1] ? 1 : int'(ref_lru));
            ref_way[w] = old_line;
            ref_way_valid[w] = 1'b1;
            ref_lru = (w == 0);
        end
        return 1'b1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic apply_reset;
        rst = 1'b1;
        fetch_cyc = 1'b0;
        fetch_stb = 1'b0;
        fetch_adr = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            ref_main_valid[s] = 1'b0;
        end
        ref_way_valid[0] = 1'b0;
        ref_way_valid[1] = 1'b0;
        ref_lru = 1'b0;
        @(negedge clk);
    endtask

    // One fetch with data, transfer count and fill address checks
    task automatic fetch_word(input logic [31:0] adr, output int latency);
        bit         miss;
        line_addr_t la;
        la = adr[31:5];
        miss = ref_access(la);
        xfer_count = 0;
        xfer_addrs.delete();
        fetch_adr = adr;
        fetch_cyc = 1'b1;
        fetch_stb = 1'b1;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
        end while (!fetch_ack);
        fetch_cyc = 1'b0;
        fetch_stb = 1'b0;
        check_value("fetch_dat", fetch_dat, adr ^ 32'hA5A5_0000);
        // An early ack leaves fewer than 8 transfers counted
        check_value("mem_transfers", xfer_count, miss ? 8 : 0);
        for (int k = 0; k < xfer_count; k++) begin
            check_value("mem_adr", xfer_addrs[k], {la, 5'b0} + 4 * k);
        end
        @(negedge clk);
    endtask

    // ==============================
    // Tests
    // ==============================

    task automatic cold_fetch;
        int lat;
        apply_reset();
        fetch_word(32'h0000_1238, lat);
        check_value("mem_transfers", xfer_count, 8);
    endtask

    task automatic same_line_hit;
        int lat;
        apply_reset();
        fetch_word(32'h0000_1238, lat);
        fetch_word(32'h0000_1224, lat);
        check_value("mem_transfers", xfer_count, 0);
        check_value("ack_latency", lat, 2);
    endtask

    task automatic victim_swap_hit;
        int lat;
        apply_reset();
        fetch_word(32'h0000_0104, lat);  // Set 0
        fetch_word(32'h0000_0208, lat);  // Set 0 again and pushes the first line out
        fetch_word(32'h0000_010C, lat);
        check_value("mem_transfers", xfer_count, 0);
        check_value("ack_latency", lat, 4);
    endtask

    task automatic lru_replacement;
        int lat;
        apply_reset();
        fetch_word(32'h0000_1000, lat);  // A
        fetch_word(32'h0000_2000, lat);  // B moves A to way 0
        fetch_word(32'h0000_3000, lat);  // C moves B to way 1
        fetch_word(32'h0000_1004, lat);  // A swaps with C and way 1 becomes LRU
        fetch_word(32'h0000_4000, lat);  // D puts A over B
        // Victim buffer holds C and A
        fetch_word(32'h0000_3008, lat);
        check_value("mem_transfers", xfer_count, 0);
        fetch_word(32'h0000_100C, lat);
        check_value("mem_transfers", xfer_count, 0);
        fetch_word(32'h0000_2010, lat);
        check_value("mem_transfers", xfer_count, 8);
    endtask

    task automatic random_wait_fill;
        int          lat;
        logic [31:0] base;
        apply_reset();
        for (int n = 0; n < 3; n++) begin
            base = 32'h0000_8000 + 32'h20 * n;
            for (int k = 0; k < `ICACHE_WORDS; k++) begin
                fetch_word(base + 4 * k, lat);
            end
        end
        // Small region for frequent set conflicts
        for (int n = 0; n < 16; n++) begin
            addr_state = xorshift(addr_state);
            fetch_word(addr_state & 32'h0000_03FC, lat);
        end
    endtask

    initial begin
        cold_fetch();
        same_line_hit();
        victim_swap_hit();
        lru_replacement();
        random_wait_fill();
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
